//--- logic/gpio_macros.svh
// GPIO register map constants

`ifndef GPIO_MACROS_SVH
`define GPIO_MACROS_SVH

// Bus widths
`define GPIO_ADDR_W 8
`define GPIO_DATA_W 16

// Address bit that picks bank 0 or bank 1
`define GPIO_BANK_BIT 5

// Word indices, taken from addr[4:2]
`define GPIO_REG_DATA_IN    3'd0
`define GPIO_REG_DATA_OUT   3'd1
`define GPIO_REG_OE         3'd2
`define GPIO_REG_IRQ_EN     3'd3
`define GPIO_REG_IRQ_STATUS 3'd4

// Cycles an input must hold still before it is accepted
`define GPIO_DEBOUNCE_CYCLES 16

`endif

//--- logic/gpio_pkg.sv
// GPIO bus and access types

`include "gpio_macros.svh"

package gpio_pkg;

   // Request from the bus master, valid is a one-cycle strobe
   typedef struct packed {
      logic                    valid;
      logic                    we;
      logic [`GPIO_ADDR_W-1:0] addr;
      logic [`GPIO_DATA_W-1:0] wdata;
   } bus_req_t;

   // One response per request
   typedef struct packed {
      logic                    valid;
      logic [`GPIO_DATA_W-1:0] rdata;
   } bus_rsp_t;

   // Decoded access for a single bank
   typedef struct packed {
      logic                    rd;
      logic                    wr;
      logic [2:0]              reg_idx;
      logic [`GPIO_DATA_W-1:0] wdata;
   } bank_acc_t;

   // Slider switches on bank 0
   typedef logic [15:0] sw_t;

   // Push buttons on bank 1
   typedef logic [4:0] btn_t;

endpackage

//--- logic/bus_decode.sv
// Bus request decode

`timescale 1ns/1ps
`include "gpio_macros.svh"

module bus_decode (
   input  logic                clk,
   input  logic                i_rst_n,
   input  gpio_pkg::bus_req_t  i_req,
   output gpio_pkg::bank_acc_t o_acc0,
   output gpio_pkg::bank_acc_t o_acc1,
   output logic                o_rd_bank,
   output logic                o_rsp_pend
);

   // Registered request fields
   logic                    req_vld_q;
   logic                    req_we_q;
   logic                    req_bank_q;
   logic [2:0]              req_idx_q;
   logic [`GPIO_DATA_W-1:0] req_wdata_q;

   // **************************************************
   // Request capture
   // **************************************************

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         req_vld_q <= 1'b0;
      end else begin
         req_vld_q <= i_req.valid;
      end
   end

   // Payload only, loaded on every strobe
   always_ff @(posedge clk) begin
      if (i_req.valid) begin
         req_we_q    <= i_req.we;
         req_bank_q  <= i_req.addr[`GPIO_BANK_BIT];
         req_idx_q   <= i_req.addr[4:2];
         req_wdata_q <= i_req.wdata;
      end
   end

   // **************************************************
   // Bank split
   // **************************************************

   always_comb begin
      o_acc0         = '0;
      o_acc1         = '0;
      o_acc0.reg_idx = req_idx_q;
      o_acc1.reg_idx = req_idx_q;
      o_acc0.wdata   = req_wdata_q;
      o_acc1.wdata   = req_wdata_q;
      // Only the selected bank sees a strobe
      o_acc0.rd      = req_vld_q & ~req_we_q & ~req_bank_q;
      o_acc0.wr      = req_vld_q &  req_we_q & ~req_bank_q;
      o_acc1.rd      = req_vld_q & ~req_we_q &  req_bank_q;
      o_acc1.wr      = req_vld_q &  req_we_q &  req_bank_q;
   end

   // Response stage picks its read data with this
   assign o_rd_bank  = req_bank_q;
   assign o_rsp_pend = req_vld_q;

   // Never both banks in one cycle
   a_one_bank: assert property (@(posedge clk) disable iff (!i_rst_n)
      !((o_acc0.rd | o_acc0.wr) && (o_acc1.rd | o_acc1.wr)));

endmodule

//--- logic/input_debounce.sv
// Input synchronizer and debounce

`timescale 1ns/1ps
`include "gpio_macros.svh"

module input_debounce #(
   parameter type T = logic
) (
   input  logic clk,
   input  logic i_rst_n,
   input  T     i_raw,
   output T     o_clean
);

   localparam int CNT_W = $clog2(`GPIO_DEBOUNCE_CYCLES + 1);
   localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'(`GPIO_DEBOUNCE_CYCLES);

   // Two-flop synchronizer
   T sync1_q;
   T sync2_q;

   // Stability counter, saturates at CNT_MAX
   logic [CNT_W-1:0] cnt_q;

   // Accepted value
   T clean_q;

   // **************************************************
   // Synchronizer
   // **************************************************

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         sync1_q <= '0;
         sync2_q <= '0;
      end else begin
         sync1_q <= i_raw;
         sync2_q <= sync1_q;
      end
   end

   // **************************************************
   // Stability count and load
   // **************************************************

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         cnt_q   <= '0;
         clean_q <= '0;
      end else begin
         // sync2 is about to take a new value, start over
         if (sync1_q != sync2_q) begin
            cnt_q <= '0;
         end else if (cnt_q != CNT_MAX) begin
            cnt_q <= cnt_q + 1'b1;
         end
         // Held long enough
         if (cnt_q == CNT_MAX) begin
            clean_q <= sync2_q;
         end
      end
   end

   assign o_clean = clean_q;

endmodule

//--- logic/gpio_bank.sv
// GPIO bank registers

`timescale 1ns/1ps
`include "gpio_macros.svh"

module gpio_bank #(
   parameter int IN_W = 16
) (
   input  logic                    clk,
   input  logic                    i_rst_n,
   input  gpio_pkg::bank_acc_t     i_acc,
   input  logic [IN_W-1:0]         i_pins,
   output logic [`GPIO_DATA_W-1:0] o_rdata,
   output logic [`GPIO_DATA_W-1:0] o_pins,
   output logic [`GPIO_DATA_W-1:0] o_pins_oe,
   output logic [`GPIO_DATA_W-1:0] o_irq_vec
);

   localparam int DW = `GPIO_DATA_W;

   // Software visible registers
   logic [DW-1:0]   out_q;
   logic [DW-1:0]   oe_q;
   logic [DW-1:0]   ien_q;
   logic [DW-1:0]   sts_q;

   // Previous debounced input for edge detect
   logic [IN_W-1:0] pins_prev_q;

   // Write strobes per register
   logic            wr_out;
   logic            wr_oe;
   logic            wr_ien;
   logic            wr_sts;

   // Bits that moved this cycle, zero-extended
   logic [DW-1:0]   change;
   logic [DW-1:0]   sts_clr;

   assign wr_out = i_acc.wr && (i_acc.reg_idx == `GPIO_REG_DATA_OUT);
   assign wr_oe  = i_acc.wr && (i_acc.reg_idx == `GPIO_REG_OE);
   assign wr_ien = i_acc.wr && (i_acc.reg_idx == `GPIO_REG_IRQ_EN);
   assign wr_sts = i_acc.wr && (i_acc.reg_idx == `GPIO_REG_IRQ_STATUS);

   assign change  = DW'(i_pins ^ pins_prev_q);
   // Write 1 to clear
   assign sts_clr = wr_sts ? i_acc.wdata : '0;

   // **************************************************
   // Register updates
   // **************************************************

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         out_q       <= '0;
         oe_q        <= '0;
         ien_q       <= '0;
         sts_q       <= '0;
         pins_prev_q <= '0;
      end else begin
         if (wr_out) begin
            out_q <= i_acc.wdata;
         end
         if (wr_oe) begin
            oe_q <= i_acc.wdata;
         end
         if (wr_ien) begin
            ien_q <= i_acc.wdata;
         end
         // A new change beats a clear on the same bit
         sts_q       <= (sts_q & ~sts_clr) | change;
         pins_prev_q <= i_pins;
      end
   end

   // **************************************************
   // Read mux
   // **************************************************

   // Zero unless this bank is read, so writes return 0
   always_comb begin
      o_rdata = '0;
      if (i_acc.rd) begin
         case (i_acc.reg_idx)
            `GPIO_REG_DATA_IN:    o_rdata = DW'(i_pins);
            `GPIO_REG_DATA_OUT:   o_rdata = out_q;
            `GPIO_REG_OE:         o_rdata = oe_q;
            `GPIO_REG_IRQ_EN:     o_rdata = ien_q;
            `GPIO_REG_IRQ_STATUS: o_rdata = sts_q;
            default:              o_rdata = '0;
         endcase
      end
   end

   assign o_pins    = out_q;
   assign o_pins_oe = oe_q;
   assign o_irq_vec = sts_q & ien_q;

   // Decode hands over a read or a write, never both
   a_rd_wr_excl: assert property (@(posedge clk) disable iff (!i_rst_n)
      !(i_acc.rd && i_acc.wr));

endmodule

//--- logic/bus_respond.sv
// Response and interrupt stage

`timescale 1ns/1ps
`include "gpio_macros.svh"

module bus_respond (
   input  logic                    clk,
   input  logic                    i_rst_n,
   input  logic                    i_rsp_pend,
   input  logic                    i_rd_bank,
   input  logic [`GPIO_DATA_W-1:0] i_rdata0,
   input  logic [`GPIO_DATA_W-1:0] i_rdata1,
   input  logic [`GPIO_DATA_W-1:0] i_irq_vec0,
   input  logic [`GPIO_DATA_W-1:0] i_irq_vec1,
   output gpio_pkg::bus_rsp_t      o_rsp,
   output logic                    o_irq
);

   logic                    rsp_vld_q;
   logic [`GPIO_DATA_W-1:0] rdata_q;
   logic                    irq_q;

   // Control flops
   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         rsp_vld_q <= 1'b0;
         irq_q     <= 1'b0;
      end else begin
         rsp_vld_q <= i_rsp_pend;
         // Any masked bit in either bank
         irq_q     <= |(i_irq_vec0 | i_irq_vec1);
      end
   end

   // Read data from the addressed bank
   always_ff @(posedge clk) begin
      if (i_rsp_pend) begin
         rdata_q <= i_rd_bank ? i_rdata1 : i_rdata0;
      end
   end

   assign o_rsp.valid = rsp_vld_q;
   assign o_rsp.rdata = rdata_q;
   assign o_irq       = irq_q;

   // One response per pending access, exactly a cycle later
   a_rsp_follows: assert property (@(posedge clk) disable iff (!i_rst_n)
      i_rsp_pend |=> o_rsp.valid);

endmodule

//--- logic/gpio_subsys.sv
// GPIO subsystem top

`timescale 1ns/1ps

module gpio_subsys (
   input  logic               clk,
   input  logic               i_rst_n,
   input  gpio_pkg::bus_req_t i_req,
   output gpio_pkg::bus_rsp_t o_rsp,
   input  gpio_pkg::sw_t      i_sw,
   input  gpio_pkg::btn_t     i_btn,
   output logic [15:0]        o_led,
   output logic [15:0]        o_led_oe,
   output logic [15:0]        o_seg,
   output logic [15:0]        o_seg_oe,
   output logic               o_irq
);

   // Decoded accesses
   gpio_pkg::bank_acc_t acc0;
   gpio_pkg::bank_acc_t acc1;
   logic                rd_bank;
   logic                rsp_pend;

   // Debounced inputs
   gpio_pkg::sw_t       sw_clean;
   gpio_pkg::btn_t      btn_clean;

   // Bank to response stage
   logic [15:0]         rdata0;
   logic [15:0]         rdata1;
   logic [15:0]         irq_vec0;
   logic [15:0]         irq_vec1;

   // **************************************************
   // Input side
   // **************************************************

   bus_decode u_decode (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_req      (i_req),
      .o_acc0     (acc0),
      .o_acc1     (acc1),
      .o_rd_bank  (rd_bank),
      .o_rsp_pend (rsp_pend)
   );

   input_debounce #(.T(gpio_pkg::sw_t)) sw_db (
      .clk     (clk),
      .i_rst_n (i_rst_n),
      .i_raw   (i_sw),
      .o_clean (sw_clean)
   );

   input_debounce #(.T(gpio_pkg::btn_t)) btn_db (
      .clk     (clk),
      .i_rst_n (i_rst_n),
      .i_raw   (i_btn),
      .o_clean (btn_clean)
   );

   // **************************************************
   // Banks
   // **************************************************

   // Switches in, LEDs out
   gpio_bank #(.IN_W($bits(gpio_pkg::sw_t))) bank0 (
      .clk       (clk),
      .i_rst_n   (i_rst_n),
      .i_acc     (acc0),
      .i_pins    (sw_clean),
      .o_rdata   (rdata0),
      .o_pins    (o_led),
      .o_pins_oe (o_led_oe),
      .o_irq_vec (irq_vec0)
   );

   // Buttons in, anodes and segments out
   gpio_bank #(.IN_W($bits(gpio_pkg::btn_t))) bank1 (
      .clk       (clk),
      .i_rst_n   (i_rst_n),
      .i_acc     (acc1),
      .i_pins    (btn_clean),
      .o_rdata   (rdata1),
      .o_pins    (o_seg),
      .o_pins_oe (o_seg_oe),
      .o_irq_vec (irq_vec1)
   );

   // **************************************************
   // Output side
   // **************************************************

   bus_respond u_respond (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_rsp_pend (rsp_pend),
      .i_rd_bank  (rd_bank),
      .i_rdata0   (rdata0),
      .i_rdata1   (rdata1),
      .i_irq_vec0 (irq_vec0),
      .i_irq_vec1 (irq_vec1),
      .o_rsp      (o_rsp),
      .o_irq      (o_irq)
   );

endmodule

//--- test/tb_gpio_subsys.sv
// GPIO subsystem testbench

`timescale 1ns/1ps
`include "gpio_macros.svh"

module tb_gpio_subsys;

   localparam int NUM_RW      = 40;
   localparam int NUM_BURSTS  = 10;
   localparam int BURST_LEN   = 8;
   localparam int NUM_PHASES  = 12;
   localparam int PHASE_CYC   = 4 * `GPIO_DEBOUNCE_CYCLES;
   // Reset reads, write/read pairs, bursts, then seven requests per input phase
   localparam int NUM_REQS    = 10 + 2 * NUM_RW + NUM_BURSTS * BURST_LEN + 7 * NUM_PHASES;
   localparam int TIMEOUT_CYC = NUM_REQS * 12 + NUM_PHASES * PHASE_CYC + 200;

   logic               clk;
   logic               i_rst_n;
   gpio_pkg::bus_req_t i_req;
   gpio_pkg::bus_rsp_t o_rsp;
   gpio_pkg::sw_t      i_sw;
   gpio_pkg::btn_t     i_btn;
   logic [15:0]        o_led;
   logic [15:0]        o_led_oe;
   logic [15:0]        o_seg;
   logic [15:0]        o_seg_oe;
   logic               o_irq;

   // Register model, index is the bank
   logic [15:0] m_out [2];
   logic [15:0] m_oe  [2];
   logic [15:0] m_ien [2];
   logic [15:0] m_sts [2];
   logic [15:0] m_in  [2];

   // Requests in flight, expected data and issue cycle
   logic [15:0] exp_q [$];
   int          iss_q [$];

   int     cyc = 0;
   int     checks = 0;
   int     mismatches = 0;
   int     failures = 0;
   integer seed;

   gpio_subsys uut (
      .clk      (clk),
      .i_rst_n  (i_rst_n),
      .i_req    (i_req),
      .o_rsp    (o_rsp),
      .i_sw     (i_sw),
      .i_btn    (i_btn),
      .o_led    (o_led),
      .o_led_oe (o_led_oe),
      .o_seg    (o_seg),
      .o_seg_oe (o_seg_oe),
      .o_irq    (o_irq)
   );

   // 20 ns clock
   initial clk = 1'b0;
   always #10 clk = ~clk;

   always @(posedge clk) begin
      cyc <= cyc + 1;
   end

   // **************************************************
   // Helpers
   // **************************************************

   task automatic compare_word(input string name, input logic [15:0] exp_v,
                               input logic [15:0] got_v);
      checks++;
      if (got_v !== exp_v) begin
         mismatches++;
         $display("MISMATCH %s exp %04h got %04h at %0t", name, exp_v, got_v, $time);
      end
   endtask

   // Register view as the map defines it
   function automatic logic [15:0] model_read(input int b, input logic [2:0] idx);
      case (idx)
         `GPIO_REG_DATA_IN:    return m_in[b];
         `GPIO_REG_DATA_OUT:   return m_out[b];
         `GPIO_REG_OE:         return m_oe[b];
         `GPIO_REG_IRQ_EN:     return m_ien[b];
         `GPIO_REG_IRQ_STATUS: return m_sts[b];
         default:              return 16'h0;
      endcase
   endfunction

   // Update the model in issue order, then strobe one request
   task automatic send_request(input int b, input logic we, input logic [2:0] idx,
                               input logic [15:0] wdata);
      gpio_pkg::bus_req_t req;
      logic [15:0]        exp_data;
      req                      = '0;
      req.valid                = 1'b1;
      req.we                   = we;
      req.addr[`GPIO_BANK_BIT] = b[0];
      req.addr[4:2]            = idx;
      req.wdata                = wdata;
      exp_data                 = 16'h0;
      if (we) begin
         case (idx)
            `GPIO_REG_DATA_OUT:   m_out[b] = wdata;
            `GPIO_REG_OE:         m_oe[b]  = wdata;
            `GPIO_REG_IRQ_EN:     m_ien[b] = wdata;
            `GPIO_REG_IRQ_STATUS: m_sts[b] = m_sts[b] & ~wdata;
            default:              ;
         endcase
      end else begin
         exp_data = model_read(b, idx);
      end
      @(posedge clk);
      i_req <= req;
      exp_q.push_back(exp_data);
   endtask

   task automatic bus_idle;
      @(posedge clk);
      i_req <= '0;
   endtask

   // Wait for every outstanding response
   task automatic wait_responses;
      int wait_cyc;
      wait_cyc = 0;
      while (exp_q.size() != 0 && wait_cyc < 8) begin
         @(posedge clk);
         wait_cyc++;
      end
      if (exp_q.size() != 0) begin
         failures++;
         $display("Responses still outstanding after %0d idle cycles", wait_cyc);
         exp_q.delete();
         iss_q.delete();
      end
      // o_irq trails the registers by a cycle
      repeat (2) @(negedge clk);
   endtask

   task automatic check_pins;
      logic irq_exp;
      irq_exp = |((m_sts[0] & m_ien[0]) | (m_sts[1] & m_ien[1]));
      compare_word("o_led", m_out[0], o_led);
      compare_word("o_led_oe", m_oe[0], o_led_oe);
      compare_word("o_seg", m_out[1], o_seg);
      compare_word("o_seg_oe", m_oe[1], o_seg_oe);
      compare_word("o_irq", 16'(irq_exp), 16'(o_irq));
   endtask

   // **************************************************
   // Response monitor
   // **************************************************

   // Falling edge, everything driven on the rising edge is stable
   always @(negedge clk) begin
      if (i_rst_n) begin
         if (i_req.valid) begin
            iss_q.push_back(cyc);
         end
         if (o_rsp.valid) begin
            if (exp_q.size() == 0 || iss_q.size() == 0) begin
               failures++;
               $display("Response arrived with no request outstanding at %0t", $time);
            end else begin
               compare_word("o_rsp.rdata", exp_q.pop_front(), o_rsp.rdata);
               compare_word("o_rsp.valid latency", 16'd2, 16'(cyc - iss_q.pop_front()));
            end
         end else if (iss_q.size() != 0 && exp_q.size() != 0 && cyc - iss_q[0] >= 2) begin
            failures++;
            $display("No response for the request issued at cycle %0d", iss_q[0]);
            void'(iss_q.pop_front());
            void'(exp_q.pop_front());
         end
      end
   end

   // **************************************************
   // Stimulus
   // **************************************************

   initial begin
      int             b;
      logic           we;
      logic [2:0]     idx;
      logic [15:0]    data;
      gpio_pkg::sw_t  sw_new;
      gpio_pkg::btn_t btn_new;
      seed    = 32'h62fe;
      i_rst_n = 1'b0;
      i_req   = '0;
      i_sw    = '0;
      i_btn   = '0;
      for (int k = 0; k < 2; k++) begin
         m_out[k] = 16'h0;
         m_oe[k]  = 16'h0;
         m_ien[k] = 16'h0;
         m_sts[k] = 16'h0;
         m_in[k]  = 16'h0;
      end
      repeat (3) @(posedge clk);
      i_rst_n <= 1'b1;

      // Reset state, all five registers of both banks
      @(negedge clk);
      check_pins();
      for (int i = 0; i < 10; i++) begin
         send_request(i / 5, 1'b0, 3'(i % 5), 16'h0);
      end
      bus_idle();
      wait_responses();

      // Write then read back, unmapped indices included in the reads
      for (int i = 0; i < NUM_RW; i++) begin
         b    = $random(seed) & 1;
         idx  = 3'(1 + ($unsigned($random(seed)) % 3));
         data = 16'($random(seed));
         send_request(b, 1'b1, idx, data);
         b    = $random(seed) & 1;
         idx  = 3'($random(seed));
         send_request(b, 1'b0, idx, 16'h0);
         bus_idle();
         wait_responses();
         check_pins();
      end

      // Consecutive strobes of mixed reads and writes
      for (int n = 0; n < NUM_BURSTS; n++) begin
         for (int i = 0; i < BURST_LEN; i++) begin
            b    = $random(seed) & 1;
            we   = 1'($random(seed));
            idx  = 3'($random(seed));
            data = 16'($random(seed));
            send_request(b, we, idx, data);
         end
         bus_idle();
         wait_responses();
         check_pins();
      end

      // Input phases, debounce then interrupt status
      for (int p = 0; p < NUM_PHASES; p++) begin
         sw_new  = 16'($random(seed));
         btn_new = 5'($random(seed));
         @(posedge clk);
         i_sw  <= sw_new;
         i_btn <= btn_new;
         // Changed bits set status once the debounced value moves
         m_sts[0] = m_sts[0] | (m_in[0] ^ 16'(sw_new));
         m_sts[1] = m_sts[1] | (m_in[1] ^ 16'(btn_new));
         m_in[0]  = 16'(sw_new);
         m_in[1]  = 16'(btn_new);
         repeat (PHASE_CYC) @(posedge clk);
         send_request(0, 1'b0, `GPIO_REG_DATA_IN, 16'h0);
         send_request(1, 1'b0, `GPIO_REG_DATA_IN, 16'h0);
         send_request(0, 1'b0, `GPIO_REG_IRQ_STATUS, 16'h0);
         send_request(1, 1'b0, `GPIO_REG_IRQ_STATUS, 16'h0);
         bus_idle();
         wait_responses();
         check_pins();
         // New mask, then clear a random subset
         b    = $random(seed) & 1;
         data = 16'($random(seed));
         send_request(b, 1'b1, `GPIO_REG_IRQ_EN, data);
         b    = $random(seed) & 1;
         data = 16'($random(seed));
         send_request(b, 1'b1, `GPIO_REG_IRQ_STATUS, data);
         send_request(b, 1'b0, `GPIO_REG_IRQ_STATUS, 16'h0);
         bus_idle();
         wait_responses();
         check_pins();
      end

      $display("Checks %0d, mismatches %0d, other failures %0d", checks, mismatches, failures);
      if (mismatches == 0 && failures == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

   // Watchdog
   initial begin
      repeat (TIMEOUT_CYC) @(posedge clk);
      $display("Run did not finish within %0d cycles", TIMEOUT_CYC);
      $display("ERRORS FOUND");
      $finish;
   end

endmodule

//--- gpio_subsys.f
+incdir+logic
logic/gpio_pkg.sv
logic/bus_decode.sv
logic/input_debounce.sv
logic/gpio_bank.sv
logic/bus_respond.sv
logic/gpio_subsys.sv
test/tb_gpio_subsys.sv

//--- Makefile
TB_TOP = tb_gpio_subsys

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f gpio_subsys.f \
		--top-module $(TB_TOP) -o $(TB_TOP)

run: build
	@out="$$(./obj_dir/$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "NO ERRORS"

lint:
	verilator --lint-only -Wall --timing -f gpio_subsys.f --top-module gpio_subsys

clean:
	rm -rf obj_dir
